//--- list.f
rtl/bp_pkg.sv
rtl/branch_target_buffer.sv
rtl/direction_predictor.sv
rtl/mispredict_resolver.sv
rtl/perf_counter_bank.sv
rtl/csr_read_fsm.sv
rtl/branch_unit_top.sv
verification/branch_unit_sva.sv
verification/branch_unit_tb.sv

//--- verification/branch_unit_tb.sv
`timescale 1ns/1ps

module branch_unit_tb;
  import bp_pkg::*;

  // roughly 80 cycles of directed traffic plus a wide margin
  localparam int MAX_CYCLES = 2000;
  // settle time after a falling-edge drive
  localparam int SETTLE     = 2;
  localparam int CYCLE_GAP  = 10;

  logic      clk, rstn;
  addr_t     fetch_pc, pred_target, redirect_pc;
  addr_t     res_pc, res_target, res_pred_target;
  logic      pred_hit, pred_taken, redirect;
  logic      res_valid, res_branch, res_jump, res_taken, res_pred_taken;
  csr_addr_t araddr;
  logic      arvalid, arready, rvalid, rready;
  perf_cnt_t rdata;
  axi_resp_t rresp;

  // expected event tallies
  perf_cnt_t exp_cond, exp_jump, exp_correct;
  int        cycle_cnt;

  branch_unit_top #(.BTB_INDEX_BITS(4)) dut (.*);

  bind branch_unit_top branch_unit_sva sva (.*);

  // 8 ns clock
  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt++;
    if (dut.sva.err_count != 0) begin
      abort_run("a bound assertion failed");
    end else if (cycle_cnt >= MAX_CYCLES) begin
      abort_run("run did not finish within the cycle limit");
    end
  end

  task automatic abort_run(string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "stopped at first error");
  endtask

  ////////////////////////////////////////////////////////////
  // compares
  ////////////////////////////////////////////////////////////
  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) abort_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_addr(string name, addr_t got, addr_t exp);
    if (got !== exp) abort_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_cnt(string name, perf_cnt_t got, perf_cnt_t exp);
    if (got !== exp) abort_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_resp(string name, axi_resp_t got, axi_resp_t exp);
    if (got !== exp) abort_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  // random word address on a chosen table index
  function automatic addr_t rand_pc(logic [3:0] idx);
    addr_t pc;
    pc      = $urandom;
    pc[5:2] = idx;
    pc[1:0] = 2'b00;
    return pc;
  endfunction

  function automatic addr_t rand_target();
    return $urandom & 32'hffff_fffc;
  endfunction

  ////////////////////////////////////////////////////////////
  // bus drivers
  ////////////////////////////////////////////////////////////
  task automatic lookup(addr_t pc, logic hit, logic taken, addr_t target);
    @(negedge clk);
    fetch_pc = pc;
    #SETTLE;
    check_bit("pred_hit", pred_hit, hit);
    check_bit("pred_taken", pred_taken, taken);
    if (hit) check_addr("pred_target", pred_target, target);
  endtask

  task automatic resolve(logic jump, addr_t pc, logic taken, addr_t target,
                         logic ptaken, addr_t ptarget, logic exp_redir, addr_t exp_pc);
    @(negedge clk);
    res_valid       = 1'b1;
    res_branch      = !jump;
    res_jump        = jump;
    res_pc          = pc;
    res_taken       = taken;
    res_target      = target;
    res_pred_taken  = ptaken;
    res_pred_target = ptarget;
    #SETTLE;
    check_bit("redirect", redirect, exp_redir);
    if (exp_redir) check_addr("redirect_pc", redirect_pc, exp_pc);
    // events the counters should have seen
    if (jump) exp_jump++;
    else exp_cond++;
    if (!jump && !exp_redir) exp_correct++;
    @(negedge clk);
    res_valid = 1'b0;
  endtask

  // one read with rready held low for hold cycles
  task automatic csr_read(csr_addr_t addr, int hold, output perf_cnt_t data,
                          output axi_resp_t resp);
    perf_cnt_t held;
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    while (!arready) @(negedge clk);
    @(negedge clk);
    arvalid = 1'b0;
    // response due the cycle after the handshake
    check_bit("rvalid", rvalid, 1'b1);
    held = rdata;
    repeat (hold) begin
      @(negedge clk);
      check_bit("rvalid", rvalid, 1'b1);
      check_cnt("rdata", rdata, held);
    end
    data   = rdata;
    resp   = rresp;
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
    check_bit("rvalid", rvalid, 1'b0);
  endtask

  task automatic read_expect(csr_addr_t addr, perf_cnt_t exp_data, axi_resp_t exp_resp);
    perf_cnt_t d;
    axi_resp_t r;
    csr_read(addr, 0, d, r);
    check_cnt("rdata", d, exp_data);
    check_resp("rresp", r, exp_resp);
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////
  task automatic test_reset_state();
    check_bit("arready", arready, 1'b1);
    check_bit("rvalid", rvalid, 1'b0);
    check_bit("redirect", redirect, 1'b0);
    repeat (8) lookup(rand_target(), 1'b0, 1'b0, '0);
    read_expect(CSR_COND, '0, RESP_OKAY);
    read_expect(CSR_JUMP, '0, RESP_OKAY);
    read_expect(CSR_CORRECT, '0, RESP_OKAY);
  endtask

  task automatic test_branch_training();
    addr_t pc, tgt;
    pc  = rand_pc(4'd3);
    tgt = rand_target();
    // cold taken branch moves the counter from 01 to 10
    resolve(1'b0, pc, 1'b1, tgt, 1'b0, '0, 1'b1, tgt);
    lookup(pc, 1'b1, 1'b1, tgt);
    resolve(1'b0, pc, 1'b1, tgt, 1'b1, tgt, 1'b0, '0);
  endtask

  task automatic test_direction_miss();
    addr_t pc, tgt;
    pc  = rand_pc(4'd5);
    tgt = rand_target();
    resolve(1'b0, pc, 1'b1, tgt, 1'b0, '0, 1'b1, tgt);
    lookup(pc, 1'b1, 1'b1, tgt);
    // wrong taken guess falls through and the counter drops to 01
    resolve(1'b0, pc, 1'b0, tgt, 1'b1, tgt, 1'b1, pc + 32'd4);
    lookup(pc, 1'b1, 1'b0, tgt);
  endtask

  task automatic test_jumps();
    addr_t pc, tgt_a, tgt_b;
    pc    = rand_pc(4'd9);
    tgt_a = rand_target();
    tgt_b = tgt_a ^ 32'h0000_0100;
    resolve(1'b1, pc, 1'b1, tgt_a, 1'b0, '0, 1'b1, tgt_a);
    // jump flag forces taken with the counter still at 01
    lookup(pc, 1'b1, 1'b1, tgt_a);
    resolve(1'b1, pc, 1'b1, tgt_a, 1'b1, tgt_a, 1'b0, '0);
    resolve(1'b1, pc, 1'b1, tgt_b, 1'b1, tgt_a, 1'b1, tgt_b);
    lookup(pc, 1'b1, 1'b1, tgt_b);
  endtask

  task automatic test_counter_readout();
    perf_cnt_t c0, c1;
    axi_resp_t r;
    read_expect(CSR_COND, exp_cond, RESP_OKAY);
    read_expect(CSR_JUMP, exp_jump, RESP_OKAY);
    read_expect(CSR_CORRECT, exp_correct, RESP_OKAY);
    csr_read(CSR_CYCLES, 0, c0, r);
    repeat (CYCLE_GAP) @(negedge clk);
    csr_read(CSR_CYCLES, 0, c1, r);
    if (c1 - c0 < CYCLE_GAP) begin
      abort_run($sformatf("cycle counter advanced by %0d over a gap of %0d cycles",
                          c1 - c0, CYCLE_GAP));
    end
    // unmapped slot
    read_expect(4'h2, '0, RESP_SLVERR);
    // back-pressure on a moving counter
    csr_read(CSR_CYCLES, 6, c0, r);
    check_resp("rresp", r, RESP_OKAY);
  endtask

  initial begin
    void'($urandom(32'hea4f_71b0));
    clk             = 1'b0;
    rstn            = 1'b0;
    fetch_pc        = '0;
    res_valid       = 1'b0;
    res_branch      = 1'b0;
    res_jump        = 1'b0;
    res_pc          = '0;
    res_taken       = 1'b0;
    res_target      = '0;
    res_pred_taken  = 1'b0;
    res_pred_target = '0;
    araddr          = '0;
    arvalid         = 1'b0;
    rready          = 1'b0;
    exp_cond        = '0;
    exp_jump        = '0;
    exp_correct     = '0;
    cycle_cnt       = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    test_reset_state();
    test_branch_training();
    test_direction_miss();
    test_jumps();
    test_counter_readout();
    if (dut.sva.err_count != 0) begin
      abort_run("a bound assertion failed");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

//--- verification/branch_unit_sva.sv
`timescale 1ns/1ps

module branch_unit_sva (
  input logic              clk,
  input logic              rstn,
  input logic              arready,
  input logic              rvalid,
  input logic              rready,
  input bp_pkg::perf_cnt_t rdata,
  input logic              res_valid,
  input logic              redirect
);

  // failures seen so far, polled by the testbench
  int unsigned err_count = 0;

  ////////////////////////////////////////////////////////////
  // read channel
  ////////////////////////////////////////////////////////////

  // response and data held until the master takes it
  a_r_hold: assert property (@(posedge clk) disable iff (!rstn)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else begin
      $error("read response dropped or changed under back-pressure");
      err_count++;
    end

  // no new address while a response waits
  a_ar_block: assert property (@(posedge clk) disable iff (!rstn)
    rvalid |-> !arready)
    else begin
      $error("arready high while a read response is pending");
      err_count++;
    end

  ////////////////////////////////////////////////////////////
  // resolve side
  ////////////////////////////////////////////////////////////

  // redirect only alongside a resolve event
  a_redirect: assert property (@(posedge clk) disable iff (!rstn)
    redirect |-> res_valid)
    else begin
      $error("redirect raised without res_valid");
      err_count++;
    end

endmodule

//--- rtl/branch_unit_top.sv
`timescale 1ns/1ps

module branch_unit_top #(
  parameter int BTB_INDEX_BITS = 4
) (
  input  logic              clk,
  input  logic              rstn,
  // fetch-side lookup
  input  bp_pkg::addr_t     fetch_pc,
  output logic              pred_hit,
  output logic              pred_taken,
  output bp_pkg::addr_t     pred_target,
  // resolve port
  input  logic              res_valid,
  input  logic              res_branch,
  input  logic              res_jump,
  input  bp_pkg::addr_t     res_pc,
  input  logic              res_taken,
  input  bp_pkg::addr_t     res_target,
  input  logic              res_pred_taken,
  input  bp_pkg::addr_t     res_pred_target,
  output logic              redirect,
  output bp_pkg::addr_t     redirect_pc,
  // axi4-lite read channels
  input  bp_pkg::csr_addr_t araddr,
  input  logic              arvalid,
  output logic              arready,
  output logic              rvalid,
  input  logic              rready,
  output bp_pkg::perf_cnt_t rdata,
  output bp_pkg::axi_resp_t rresp
);
  import bp_pkg::*;

  logic      btb_is_jump;
  logic      dir_taken;
  logic      btb_update;
  logic      pred_update;
  logic      cond_event;
  logic      jump_event;
  logic      correct_event;
  perf_cnt_t cycles;
  perf_cnt_t cond_count;
  perf_cnt_t jump_count;
  perf_cnt_t correct_count;

  ////////////////////////////////////////////////////////////
  // prediction
  ////////////////////////////////////////////////////////////
  branch_target_buffer #(.BTB_INDEX_BITS(BTB_INDEX_BITS)) m_btb (
    .clk           (clk),
    .rstn          (rstn),
    .lookup_pc     (fetch_pc),
    .update_en     (btb_update),
    .update_pc     (res_pc),
    .update_target (res_target),
    .update_jump   (res_jump),
    .hit           (pred_hit),
    .is_jump       (btb_is_jump),
    .target        (pred_target)
  );

  direction_predictor #(.BTB_INDEX_BITS(BTB_INDEX_BITS)) m_dir (
    .clk           (clk),
    .rstn          (rstn),
    .lookup_pc     (fetch_pc),
    .update_en     (pred_update),
    .update_pc     (res_pc),
    .taken         (res_taken),
    .predict_taken (dir_taken)
  );

  // jumps predict taken regardless of the counter
  assign pred_taken = pred_hit && (btb_is_jump || dir_taken);

  ////////////////////////////////////////////////////////////
  // resolution, counters, readout
  ////////////////////////////////////////////////////////////
  mispredict_resolver m_resolver (
    .res_valid       (res_valid),
    .res_branch      (res_branch),
    .res_jump        (res_jump),
    .res_pc          (res_pc),
    .res_target      (res_target),
    .res_pred_target (res_pred_target),
    .res_taken       (res_taken),
    .res_pred_taken  (res_pred_taken),
    .redirect        (redirect),
    .redirect_pc     (redirect_pc),
    .btb_update      (btb_update),
    .pred_update     (pred_update),
    .cond_event      (cond_event),
    .jump_event      (jump_event),
    .correct_event   (correct_event)
  );

  perf_counter_bank m_counters (
    .clk           (clk),
    .rstn          (rstn),
    .cond_event    (cond_event),
    .jump_event    (jump_event),
    .correct_event (correct_event),
    .cycles        (cycles),
    .cond_count    (cond_count),
    .jump_count    (jump_count),
    .correct_count (correct_count)
  );

  csr_read_fsm m_csr (
    .clk           (clk),
    .rstn          (rstn),
    .araddr        (araddr),
    .arvalid       (arvalid),
    .arready       (arready),
    .rvalid        (rvalid),
    .rready        (rready),
    .rdata         (rdata),
    .rresp         (rresp),
    .cycles        (cycles),
    .cond_count    (cond_count),
    .jump_count    (jump_count),
    .correct_count (correct_count)
  );

endmodule

//--- rtl/csr_read_fsm.sv
`timescale 1ns/1ps

module csr_read_fsm (
  input  logic              clk,
  input  logic              rstn,
  input  bp_pkg::csr_addr_t araddr,
  input  logic              arvalid,
  output logic              arready,
  output logic              rvalid,
  input  logic              rready,
  output bp_pkg::perf_cnt_t rdata,
  output bp_pkg::axi_resp_t rresp,
  input  bp_pkg::perf_cnt_t cycles,
  input  bp_pkg::perf_cnt_t cond_count,
  input  bp_pkg::perf_cnt_t jump_count,
  input  bp_pkg::perf_cnt_t correct_count
);
  import bp_pkg::*;

  csr_state_e state_q;
  perf_cnt_t  sel_data;
  axi_resp_t  sel_resp;
  logic       ar_hs;
  logic       r_hs;

  // one read in flight at most
  assign arready = (state_q == CSR_IDLE);
  assign rvalid  = (state_q == CSR_RESP);
  assign ar_hs   = arvalid && arready;
  assign r_hs    = rvalid && rready;

  // address decode
  always_comb begin
    sel_data = '0;
    sel_resp = RESP_OKAY;
    case (araddr)
      CSR_CYCLES:  sel_data = cycles;
      CSR_COND:    sel_data = cond_count;
      CSR_JUMP:    sel_data = jump_count;
      CSR_CORRECT: sel_data = correct_count;
      // unmapped, zero data
      default:     sel_resp = RESP_SLVERR;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // state register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      state_q <= CSR_IDLE;
    end else begin
      case (state_q)
        CSR_IDLE: if (ar_hs) state_q <= CSR_RESP;
        // wait out rready back-pressure
        CSR_RESP: if (r_hs) state_q <= CSR_IDLE;
        default:  state_q <= CSR_IDLE;
      endcase
    end
  end

  // snapshot at the address handshake, held until accepted
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rdata <= sel_data;
      rresp <= sel_resp;
    end
  end

endmodule

//--- rtl/perf_counter_bank.sv
`timescale 1ns/1ps

module perf_counter_bank (
  input  logic              clk,
  input  logic              rstn,
  input  logic              cond_event,
  input  logic              jump_event,
  input  logic              correct_event,
  output bp_pkg::perf_cnt_t cycles,
  output bp_pkg::perf_cnt_t cond_count,
  output bp_pkg::perf_cnt_t jump_count,
  output bp_pkg::perf_cnt_t correct_count
);
  import bp_pkg::*;

  localparam int NUM_CNT = 4;

  // slot order: cycles, cond, jump, correct
  perf_cnt_t          cnt_q [NUM_CNT];
  logic [NUM_CNT-1:0] inc;

  // cycle slot counts unconditionally
  assign inc = {correct_event, jump_event, cond_event, 1'b1};

  // same counter per slot, wraps on overflow
  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_CNT; i++) begin
      if (!rstn) begin
        cnt_q[i] <= '0;
      end else if (inc[i]) begin
        cnt_q[i] <= cnt_q[i] + 32'd1;
      end
    end
  end

  // visible from the cycle after the event
  assign cycles        = cnt_q[0];
  assign cond_count    = cnt_q[1];
  assign jump_count    = cnt_q[2];
  assign correct_count = cnt_q[3];

endmodule

//--- rtl/mispredict_resolver.sv
`timescale 1ns/1ps

module mispredict_resolver (
  input  logic          res_valid,
  input  logic          res_branch,
  input  logic          res_jump,
  input  bp_pkg::addr_t res_pc,
  input  bp_pkg::addr_t res_target,
  input  bp_pkg::addr_t res_pred_target,
  input  logic          res_taken,
  input  logic          res_pred_taken,
  output logic          redirect,
  output bp_pkg::addr_t redirect_pc,
  output logic          btb_update,
  output logic          pred_update,
  output logic          cond_event,
  output logic          jump_event,
  output logic          correct_event
);
  import bp_pkg::*;

  addr_t pc_plus_4;
  addr_t fix_pc;
  logic  same_target;
  logic  need_redirect;

  // fall-through address for a wrong taken guess
  assign pc_plus_4   = res_pc + 32'd4;
  assign same_target = (res_target == res_pred_target);

  ////////////////////////////////////////////////////////////
  // redirect decision
  ////////////////////////////////////////////////////////////
  always_comb begin
    need_redirect = 1'b0;
    fix_pc        = res_target;
    if (res_jump) begin
      // jumps always go, only a matching taken guess is right
      need_redirect = !(res_pred_taken && same_target);
    end else if (res_branch) begin
      // predicted / actual
      case ({res_pred_taken, res_taken})
        2'b01: need_redirect = 1'b1;
        2'b10: begin
          need_redirect = 1'b1;
          fix_pc        = pc_plus_4;
        end
        // right direction, maybe stale target
        2'b11: need_redirect = !same_target;
        default: need_redirect = 1'b0;
      endcase
    end
  end

  assign redirect    = res_valid && need_redirect;
  assign redirect_pc = redirect ? fix_pc : '0;

  // table training, lands at the end of this cycle
  assign btb_update  = res_valid && ((res_branch && res_taken) || res_jump);
  assign pred_update = res_valid && res_branch;

  // event pulses for the counters
  assign cond_event    = res_valid && res_branch;
  assign jump_event    = res_valid && res_jump;
  assign correct_event = res_valid && res_branch && !need_redirect;

endmodule

//--- rtl/direction_predictor.sv
`timescale 1ns/1ps

module direction_predictor #(
  parameter int BTB_INDEX_BITS = 4
) (
  input  logic          clk,
  input  logic          rstn,
  input  bp_pkg::addr_t lookup_pc,
  input  logic          update_en,
  input  bp_pkg::addr_t update_pc,
  input  logic          taken,
  output logic          predict_taken
);
  import bp_pkg::*;

  localparam int ENTRIES = 1 << BTB_INDEX_BITS;
  // same index bits as the btb
  localparam int IDX_MSB = BTB_INDEX_BITS + 1;

  typedef logic [BTB_INDEX_BITS-1:0] index_t;

  ctr_t   cnt_q [ENTRIES];
  index_t lookup_idx;
  index_t update_idx;
  ctr_t   cur_cnt;

  assign lookup_idx = lookup_pc[IDX_MSB:2];
  assign update_idx = update_pc[IDX_MSB:2];

  // upper bit of the counter is the guess
  assign predict_taken = cnt_q[lookup_idx][1];

  // counter being trained
  assign cur_cnt = cnt_q[update_idx];

  // training, one step per resolved branch
  always_ff @(posedge clk) begin
    if (!rstn) begin
      // every entry starts weakly not taken
      for (int i = 0; i < ENTRIES; i++) begin
        cnt_q[i] <= CTR_WEAK_NT;
      end
    end else if (update_en) begin
      if (taken) begin
        // saturate at strongly taken
        if (cur_cnt != CTR_STRONG_T) begin
          cnt_q[update_idx] <= cur_cnt + 2'b01;
        end
      end else begin
        // saturate at strongly not taken
        if (cur_cnt != CTR_STRONG_NT) begin
          cnt_q[update_idx] <= cur_cnt - 2'b01;
        end
      end
    end
  end

endmodule

//--- rtl/branch_target_buffer.sv
`timescale 1ns/1ps

module branch_target_buffer #(
  parameter int BTB_INDEX_BITS = 4
) (
  input  logic          clk,
  input  logic          rstn,
  input  bp_pkg::addr_t lookup_pc,
  input  logic          update_en,
  input  bp_pkg::addr_t update_pc,
  input  bp_pkg::addr_t update_target,
  input  logic          update_jump,
  output logic          hit,
  output logic          is_jump,
  output bp_pkg::addr_t target
);
  import bp_pkg::*;

  localparam int ENTRIES  = 1 << BTB_INDEX_BITS;
  // index sits right above the byte offset
  localparam int TAG_LSB  = BTB_INDEX_BITS + 2;
  localparam int ADDR_MSB = $bits(addr_t) - 1;
  localparam int TAG_BITS = $bits(addr_t) - TAG_LSB;

  typedef logic [BTB_INDEX_BITS-1:0] index_t;
  typedef logic [TAG_BITS-1:0]       tag_t;

  // entry state
  logic [ENTRIES-1:0] valid_q;
  logic [ENTRIES-1:0] jump_q;
  tag_t               tag_q    [ENTRIES];
  addr_t              target_q [ENTRIES];

  index_t lookup_idx;
  tag_t   lookup_tag;
  index_t update_idx;
  tag_t   update_tag;

  // split both pcs into index and tag
  assign lookup_idx = lookup_pc[TAG_LSB-1:2];
  assign lookup_tag = lookup_pc[ADDR_MSB:TAG_LSB];
  assign update_idx = update_pc[TAG_LSB-1:2];
  assign update_tag = update_pc[ADDR_MSB:TAG_LSB];

  // lookup, tag compare against old table state
  assign hit     = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
  assign is_jump = jump_q[lookup_idx];
  // target only meaningful on a hit
  assign target  = hit ? target_q[lookup_idx] : '0;

  // valid bits, all entries empty out of reset
  always_ff @(posedge clk) begin
    if (!rstn) begin
      valid_q <= '0;
    end else if (update_en) begin
      valid_q[update_idx] <= 1'b1;
    end
  end

  // entry payload
  always_ff @(posedge clk) begin
    if (update_en) begin
      tag_q[update_idx]    <= update_tag;
      target_q[update_idx] <= update_target;
      // jump flag forces a taken prediction later
      jump_q[update_idx]   <= update_jump;
    end
  end

endmodule

//--- rtl/bp_pkg.sv
package bp_pkg;

  ////////////////////////////////////////////////////////////
  // widths with a meaning
  ////////////////////////////////////////////////////////////

  // instruction address, word aligned in practice
  typedef logic [31:0] addr_t;

  // 2-bit saturating direction counter, msb is the prediction
  typedef logic [1:0] ctr_t;

  // free-running event counter
  typedef logic [31:0] perf_cnt_t;

  // byte address inside the counter block
  typedef logic [3:0] csr_addr_t;

  // axi response code
  typedef logic [1:0] axi_resp_t;

  // counter encodings
  localparam ctr_t CTR_STRONG_NT = 2'b00;
  localparam ctr_t CTR_WEAK_NT   = 2'b01;
  localparam ctr_t CTR_STRONG_T  = 2'b11;

  // axi responses in use
  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_SLVERR = 2'b10;

  ////////////////////////////////////////////////////////////
  // counter address map
  ////////////////////////////////////////////////////////////
  localparam csr_addr_t CSR_CYCLES  = 4'h0;
  localparam csr_addr_t CSR_COND    = 4'h4;
  localparam csr_addr_t CSR_JUMP    = 4'h8;
  localparam csr_addr_t CSR_CORRECT = 4'hC;

  // read channel fsm
  typedef enum logic {
    CSR_IDLE,
    CSR_RESP
  } csr_state_e;

endpackage
